/* hdl/core_pkg.sv */
package core_pkg;

    // register value and index
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_pos_t;

    // rename tag, zero means the value is ready
    typedef logic [3:0]  rob_id_t;

    localparam int REG_SIZE  = 32;
    localparam int ROB_DEPTH = 8;

    // reorder buffer pointer and occupancy
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH);
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
    typedef logic [ROB_PTR_W:0]   rob_cnt_t;

    localparam reg_pos_t ZERO_REG = 5'd0;
    localparam rob_id_t  ZERO_ROB = 4'd0;

endpackage

/* hdl/rename_pkg.sv */
package rename_pkg;

    // incoming instruction, already decoded
    typedef struct packed {
        core_pkg::reg_pos_t rd;
        core_pkg::reg_pos_t rs1;
        core_pkg::reg_pos_t rs2;
    } inst_t;

    // renamed operation with operands or producer tags
    typedef struct packed {
        logic               valid;
        core_pkg::rob_id_t  tag;
        core_pkg::data_t    v1;
        core_pkg::rob_id_t  q1;
        core_pkg::data_t    v2;
        core_pkg::rob_id_t  q2;
        core_pkg::reg_pos_t rd;
    } issue_t;

    // result coming back, jump means redirect
    typedef struct packed {
        logic              valid;
        core_pkg::rob_id_t tag;
        core_pkg::data_t   value;
        logic              jump;
    } result_t;

    typedef struct packed {
        logic               valid;
        core_pkg::rob_id_t  tag;
        core_pkg::reg_pos_t rd;
        core_pkg::data_t    value;
        logic               jump;
    } commit_t;

    // new reorder buffer entry
    typedef struct packed {
        logic               valid;
        core_pkg::reg_pos_t rd;
        core_pkg::rob_id_t  tag;
    } alloc_t;

endpackage

/* hdl/reg_file.sv */
module reg_file (
    input  logic                clk,
    input  logic                rst,

    // operand read from dispatch
    input  core_pkg::reg_pos_t  rs1,
    input  core_pkg::reg_pos_t  rs2,
    output core_pkg::data_t     v1,
    output core_pkg::data_t     v2,
    output core_pkg::rob_id_t   q1,
    output core_pkg::rob_id_t   q2,

    input  rename_pkg::alloc_t  alloc,
    input  rename_pkg::commit_t commit
);

    import core_pkg::*;
    import rename_pkg::*;

    data_t   vals [REG_SIZE];
    rob_id_t tags [REG_SIZE];

    logic    jump_clr;
    logic    alloc_wr;
    logic    commit_wr;
    logic    commit_clr;
    rob_id_t cur_tag;

    // value seen by a read, commit in flight wins
    function automatic data_t read_val(input reg_pos_t rs);
        data_t v;
        v = vals[rs];
        if (commit_wr && commit.rd == rs) begin
            v = commit.value;
        end
        return v;
    endfunction

    // tag seen by a read, cleared if the committing entry is its producer
    function automatic rob_id_t read_tag(input reg_pos_t rs);
        rob_id_t q;
        q = tags[rs];
        if (commit_wr && commit.rd == rs && tags[rs] == commit.tag) begin
            q = ZERO_ROB;
        end
        return q;
    endfunction

    always_comb begin
        jump_clr  = commit.valid && commit.jump;
        alloc_wr  = alloc.valid && alloc.rd != ZERO_REG;
        commit_wr = commit.valid && commit.rd != ZERO_REG;

        // youngest tag rd will hold after this edge, before the commit clear
        if (alloc_wr && alloc.rd == commit.rd) begin
            cur_tag = alloc.tag;
        end else begin
            cur_tag = tags[commit.rd];
        end
        commit_clr = commit_wr && cur_tag == commit.tag;
    end

    always_comb begin
        v1 = read_val(rs1);
        v2 = read_val(rs2);
        q1 = read_tag(rs1);
        q2 = read_tag(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_SIZE; i++) begin
                tags[i] <= ZERO_ROB;
                vals[i] <= '0;
            end
        end else begin
            if (jump_clr) begin
                for (int i = 0; i < REG_SIZE; i++) begin
                    tags[i] <= ZERO_ROB;
                end
            end else if (alloc_wr) begin
                tags[alloc.rd] <= alloc.tag;
            end

            // producer done and no younger writer
            if (commit_clr) begin
                tags[commit.rd] <= ZERO_ROB;
            end
            if (commit_wr) begin
                vals[commit.rd] <= commit.value;
            end
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
module reorder_buffer (
    input  logic                clk,
    input  logic                rst,

    // allocation from dispatch
    input  rename_pkg::alloc_t  alloc,
    output core_pkg::rob_id_t   next_tag,

    // out of order results
    input  rename_pkg::result_t result,

    // in order commit, combinational from head
    output rename_pkg::commit_t commit,
    output logic                full
);

    import core_pkg::*;
    import rename_pkg::*;

    rob_ptr_t head;
    rob_ptr_t tail;
    rob_cnt_t count;

    logic [ROB_DEPTH-1:0] ent_ready;
    logic [ROB_DEPTH-1:0] ent_jump;
    reg_pos_t             ent_rd    [ROB_DEPTH];
    data_t                ent_value [ROB_DEPTH];

    rob_ptr_t res_idx;
    logic     do_commit;
    logic     do_flush;

    // tag is the entry index plus one, zero stays free for "ready"
    function automatic rob_id_t tag_of(input rob_ptr_t ptr);
        return rob_id_t'(ptr) + 1'b1;
    endfunction

    assign res_idx  = rob_ptr_t'(result.tag - 1'b1);
    assign next_tag = tag_of(tail);
    assign full     = count == rob_cnt_t'(ROB_DEPTH);

    always_comb begin
        commit.valid = count != '0 && ent_ready[head];
        commit.tag   = tag_of(head);
        commit.rd    = ent_rd[head];
        commit.value = ent_value[head];
        commit.jump  = ent_jump[head];
    end

    assign do_commit = commit.valid;
    assign do_flush  = commit.valid && commit.jump;

    // pointers, count and ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_ready <= '0;
        end else if (do_flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_ready <= '0;
        end else begin
            if (alloc.valid) begin
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (result.valid) begin
                ent_ready[res_idx] <= 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end

            case ({alloc.valid, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            ent_rd[tail] <= alloc.rd;
        end
        if (result.valid) begin
            ent_value[res_idx] <= result.value;
            ent_jump[res_idx]  <= result.jump;
        end
    end

endmodule

/* hdl/dispatch.sv */
module dispatch (
    input  logic               clk,
    input  logic               rst,

    input  logic               inst_valid,
    input  rename_pkg::inst_t  inst,

    // operand read through reg_file
    output core_pkg::reg_pos_t rs1,
    output core_pkg::reg_pos_t rs2,
    input  core_pkg::data_t    v1,
    input  core_pkg::rob_id_t  q1,
    input  core_pkg::data_t    v2,
    input  core_pkg::rob_id_t  q2,

    input  core_pkg::rob_id_t  next_tag,
    input  logic               flush,

    output rename_pkg::alloc_t alloc,
    output rename_pkg::issue_t issue
);

    import core_pkg::*;
    import rename_pkg::*;

    logic take;

    // a jump commit in this cycle drops the incoming instruction
    assign take = inst_valid && !flush;

    assign rs1 = inst.rs1;
    assign rs2 = inst.rs2;

    always_comb begin
        alloc.valid = take;
        alloc.rd    = inst.rd;
        alloc.tag   = next_tag;
    end

    // renamed op, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (take) begin
            issue.tag <= next_tag;
            issue.v1  <= v1;
            issue.q1  <= q1;
            issue.v2  <= v2;
            issue.q2  <= q2;
            issue.rd  <= inst.rd;
        end

        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= take;
        end
    end

endmodule

/* hdl/rename_core.sv */
module rename_core (
    input  logic                clk,
    input  logic                rst,

    input  logic                inst_valid,
    input  rename_pkg::inst_t   inst,
    input  rename_pkg::result_t result,

    output rename_pkg::issue_t  issue,
    output rename_pkg::commit_t commit,
    output logic                rob_full
);

    import core_pkg::*;
    import rename_pkg::*;

    reg_pos_t rs1;
    reg_pos_t rs2;
    data_t    v1;
    data_t    v2;
    rob_id_t  q1;
    rob_id_t  q2;
    rob_id_t  next_tag;
    alloc_t   alloc;
    logic     flush;

    // redirect on a committed jump
    assign flush = commit.valid && commit.jump;

    dispatch dispatch0 (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .v1         (v1),
        .q1         (q1),
        .v2         (v2),
        .q2         (q2),
        .next_tag   (next_tag),
        .flush      (flush),
        .alloc      (alloc),
        .issue      (issue)
    );

    reg_file reg_file0 (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .v1     (v1),
        .v2     (v2),
        .q1     (q1),
        .q2     (q2),
        .alloc  (alloc),
        .commit (commit)
    );

    reorder_buffer rob0 (
        .clk      (clk),
        .rst      (rst),
        .alloc    (alloc),
        .next_tag (next_tag),
        .result   (result),
        .commit   (commit),
        .full     (rob_full)
    );

endmodule

/* sim/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);

    // period 4
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* sim/rename_checker.sv */
module rename_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  rename_pkg::inst_t   inst,
    input  rename_pkg::result_t result,
    input  rename_pkg::issue_t  issue,
    input  rename_pkg::commit_t commit,
    input  logic                rob_full,
    output int                  issue_errs,
    output int                  commit_errs,
    output int                  flag_errs
);

    import core_pkg::*;
    import rename_pkg::*;

    data_t   arch [REG_SIZE];
    // youngest in-flight writer per register
    rob_id_t prod [REG_SIZE];
    alloc_t  flight [$];
    logic    res_ready [ROB_DEPTH+1];
    data_t   res_value [ROB_DEPTH+1];
    logic    res_jump  [ROB_DEPTH+1];
    rob_id_t tail_tag;
    issue_t  exp_issue;

    // operand as the model sees it, head commit bypassed
    task automatic predict_src(input reg_pos_t rs, input logic head_ok, input alloc_t head,
                               output data_t v, output rob_id_t q);
        v = '0;
        q = ZERO_ROB;
        if (rs != ZERO_REG) begin
            if (prod[rs] != ZERO_ROB && !(head_ok && head.tag == prod[rs])) begin
                q = prod[rs];
            end else if (head_ok && head.rd == rs) begin
                v = res_value[head.tag];
            end else begin
                v = arch[rs];
            end
        end
    endtask

    // value only matters when no producer is pending
    task automatic check_src(input int n, input data_t v, input rob_id_t q,
                             input data_t ev, input rob_id_t eq);
        if (q != eq || (eq == ZERO_ROB && v != ev)) begin
            issue_errs++;
            $display("Fail %0t: source %0d of tag %0d reads q %0d v %h, expected q %0d v %h",
                     $time, n, issue.tag, q, v, eq, ev);
        end
    endtask

    always @(posedge clk) begin : step
        logic    head_ok;
        alloc_t  head;
        logic    flush;
        data_t   ev;
        rob_id_t eq;
        if (rst) begin
            for (int i = 0; i < REG_SIZE; i++) begin
                arch[i] = '0;
                prod[i] = ZERO_ROB;
            end
            for (int t = 0; t <= ROB_DEPTH; t++) begin
                res_ready[t] = 1'b0;
            end
            flight.delete();
            tail_tag  = 4'd1;
            exp_issue = '0;
        end else begin
            head_ok = flight.size() != 0 && res_ready[flight[0].tag];
            head    = head_ok ? flight[0] : '0;
            flush   = head_ok && res_jump[head.tag];

            if (commit.valid !== head_ok) begin
                commit_errs++;
                $display("Fail %0t: commit valid %b, expected %b", $time, commit.valid, head_ok);
            end else if (head_ok && (commit.tag != head.tag || commit.rd != head.rd ||
                         commit.value != res_value[head.tag] ||
                         commit.jump != res_jump[head.tag])) begin
                commit_errs++;
                $display("Fail %0t: commit tag %0d rd %0d value %h, expected tag %0d rd %0d value %h",
                         $time, commit.tag, commit.rd, commit.value,
                         head.tag, head.rd, res_value[head.tag]);
            end

            if (issue.valid !== exp_issue.valid) begin
                issue_errs++;
                $display("Fail %0t: issue valid %b, expected %b", $time, issue.valid,
                         exp_issue.valid);
            end else if (exp_issue.valid) begin
                if (issue.tag != exp_issue.tag || issue.rd != exp_issue.rd) begin
                    issue_errs++;
                    $display("Fail %0t: issue tag %0d rd %0d, expected tag %0d rd %0d", $time,
                             issue.tag, issue.rd, exp_issue.tag, exp_issue.rd);
                end
                check_src(1, issue.v1, issue.q1, exp_issue.v1, exp_issue.q1);
                check_src(2, issue.v2, issue.q2, exp_issue.v2, exp_issue.q2);
            end

            if (rob_full !== (flight.size() == ROB_DEPTH)) begin
                flag_errs++;
                $display("Fail %0t: rob_full %b with %0d tags in flight", $time, rob_full,
                         flight.size());
            end

            // issue expected one cycle after this strobe
            exp_issue = '0;
            if (inst_valid && !flush) begin
                exp_issue.valid = 1'b1;
                exp_issue.tag   = tail_tag;
                exp_issue.rd    = inst.rd;
                predict_src(inst.rs1, head_ok, head, ev, eq);
                exp_issue.v1 = ev;
                exp_issue.q1 = eq;
                predict_src(inst.rs2, head_ok, head, ev, eq);
                exp_issue.v2 = ev;
                exp_issue.q2 = eq;
            end

            if (head_ok) begin
                if (head.rd != ZERO_REG) begin
                    arch[head.rd] = res_value[head.tag];
                end
                if (prod[head.rd] == head.tag) begin
                    prod[head.rd] = ZERO_ROB;
                end
                void'(flight.pop_front());
            end

            if (flush) begin
                for (int i = 0; i < REG_SIZE; i++) begin
                    prod[i] = ZERO_ROB;
                end
                for (int t = 0; t <= ROB_DEPTH; t++) begin
                    res_ready[t] = 1'b0;
                end
                flight.delete();
                tail_tag = 4'd1;
            end else begin
                if (inst_valid) begin
                    res_ready[tail_tag] = 1'b0;
                    flight.push_back(alloc_t'{valid: 1'b1, rd: inst.rd, tag: tail_tag});
                    if (inst.rd != ZERO_REG) begin
                        prod[inst.rd] = tail_tag;
                    end
                    tail_tag = (tail_tag == rob_id_t'(ROB_DEPTH)) ? 4'd1 : tail_tag + 4'd1;
                end
                if (result.valid) begin
                    res_ready[result.tag] = 1'b1;
                    res_value[result.tag] = result.value;
                    res_jump[result.tag]  = result.jump;
                end
            end
        end
    end

endmodule

/* sim/tb_top.sv */
module tb_top;

    import core_pkg::*;
    import rename_pkg::*;

    localparam int N_INST = 2000;
    // about four cycles per instruction at worst
    localparam int MAX_CYCLES = N_INST * 4;

    logic    clk;
    logic    rst;
    logic    inst_valid = 1'b0;
    inst_t   inst       = '0;
    result_t result     = '0;
    issue_t  issue;
    commit_t commit;
    logic    rob_full;

    int issue_errs;
    int commit_errs;
    int flag_errs;

    logic [31:0] rng       = 32'h30f7_b555;
    int          sent      = 0;
    int          cycles    = 0;
    int          in_flight = 0;
    logic        done      = 1'b0;
    rob_id_t     tail_tag  = 4'd1;
    // allocated tags still waiting for a result
    rob_id_t     waiting [$];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // low registers half the time so sources often hit in-flight writers
    function automatic reg_pos_t pick_reg(input logic [5:0] r);
        return r[5] ? {2'b00, r[2:0]} : r[4:0];
    endfunction

    clk_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    rename_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .result     (result),
        .issue      (issue),
        .commit     (commit),
        .rob_full   (rob_full)
    );

    rename_checker checker0 (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .result      (result),
        .issue       (issue),
        .commit      (commit),
        .rob_full    (rob_full),
        .issue_errs  (issue_errs),
        .commit_errs (commit_errs),
        .flag_errs   (flag_errs)
    );

    always @(posedge clk) begin : drive
        int pick;
        if (rst) begin
            inst_valid <= 1'b0;
            result     <= '0;
            waiting.delete();
            in_flight = 0;
            tail_tag  = 4'd1;
        end else begin
            cycles <= cycles + 1;

            // what the DUT takes at this edge
            if (commit.valid && commit.jump) begin
                waiting.delete();
                in_flight = 0;
                tail_tag  = 4'd1;
            end else begin
                if (inst_valid) begin
                    waiting.push_back(tail_tag);
                    in_flight++;
                    tail_tag = (tail_tag == rob_id_t'(ROB_DEPTH)) ? 4'd1 : tail_tag + 4'd1;
                end
                if (commit.valid) begin
                    in_flight--;
                end
            end
            if (sent == N_INST && in_flight == 0) begin
                done <= 1'b1;
            end

            // in_flight is the occupancy of the next cycle
            rng = xorshift(rng);
            if (sent < N_INST && in_flight < ROB_DEPTH && rng[1:0] != 2'd0) begin
                inst_valid <= 1'b1;
                inst.rd    <= pick_reg(rng[7:2]);
                inst.rs1   <= pick_reg(rng[13:8]);
                inst.rs2   <= pick_reg(rng[19:14]);
                sent++;
            end else begin
                inst_valid <= 1'b0;
            end

            // results pause for 16 of every 128 cycles so the ROB fills up
            rng = xorshift(rng);
            if (waiting.size() != 0 && rng[2:0] != 3'd0 && cycles[6:4] != 3'd0) begin
                pick = int'(rng[10:3]) % waiting.size();
                result.valid <= 1'b1;
                result.tag   <= waiting[pick];
                result.jump  <= rng[14:11] == 4'd0;
                waiting.delete(pick);
                rng = xorshift(rng);
                result.value <= rng;
            end else begin
                result <= '0;
            end
        end
    end

    initial begin
        @(negedge rst);
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (!done) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions presented",
                     cycles, sent, N_INST);
        end
        $display("errors: issue %0d, commit %0d, rob_full %0d",
                 issue_errs, commit_errs, flag_errs);
        if (done && issue_errs + commit_errs + flag_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/core_pkg.sv
hdl/rename_pkg.sv
hdl/reg_file.sv
hdl/reorder_buffer.sv
hdl/dispatch.sv
hdl/rename_core.sv
sim/clk_gen.sv
sim/rename_checker.sv
sim/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
